/* flist.f */
common/rv32i_pkg.sv
exec/int_alu.sv
lsu/lsu_ctrl.sv
hdl/rd_writeback.sv
hdl/alu_top.sv
tb/tb_clk_gen.sv
tb/alu_top_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= alu_top_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

/* tb/alu_top_tb.sv */
// Table-driven testbench for alu_top with an inline memory responder.
// Expected results are worked out by hand from the RV32I rules, rs1 is x1 and rs2 is x2.

`timescale 1ns/1ps

module alu_top_tb;

    localparam int ADDR_W       = 16;
    localparam int PERIOD_NS    = 40;
    localparam int RESET_CYCLES = 16;
    localparam int N_TESTS      = 32;
    localparam int WATCHDOG_NS  = N_TESTS * 8 * PERIOD_NS + RESET_CYCLES * PERIOD_NS;

    // Result kinds
    localparam int K_RD    = 0;
    localparam int K_LOAD  = 1;
    localparam int K_STORE = 2;
    localparam int K_NONE  = 3;

    typedef struct {
        string             name;
        int                kind;
        logic [31:0]       instr;
        rv32i_pkg::xlen_t  rs1;
        rv32i_pkg::xlen_t  rs2;
        rv32i_pkg::xlen_t  rdata;
        rv32i_pkg::xlen_t  exp_val;
        rv32i_pkg::strb_t  exp_strb;
        logic [ADDR_W-1:0] exp_addr;
    } test_t;

    logic                 aclk;
    logic                 aresetn;
    logic                 alu_en;
    logic                 alu_ready;
    rv32i_pkg::instr_t    alu_instbus;
    rv32i_pkg::reg_addr_t alu_rs1_addr;
    rv32i_pkg::reg_addr_t alu_rs2_addr;
    rv32i_pkg::xlen_t     alu_rs1_val;
    rv32i_pkg::xlen_t     alu_rs2_val;
    logic                 alu_rd_wr;
    rv32i_pkg::reg_addr_t alu_rd_addr;
    rv32i_pkg::xlen_t     alu_rd_val;
    rv32i_pkg::strb_t     alu_rd_strb;
    logic                 mem_en;
    logic                 mem_wr;
    logic [ADDR_W-1:0]    mem_addr;
    rv32i_pkg::xlen_t     mem_wdata;
    rv32i_pkg::strb_t     mem_strb;
    rv32i_pkg::xlen_t     mem_rdata;
    logic                 mem_ready;

    test_t  tests[N_TESTS];
    int     n_tests     = 0;
    int     val_errs    = 0;
    int     proto_errs  = 0;
    int     wr_expected = 0;
    int     wr_seen     = 0;
    integer seed        = 32'hd9abfc37;

    tb_clk_gen #(
        .PERIOD_NS    (PERIOD_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_tb_clk_gen (
        .aclk    (aclk),
        .aresetn (aresetn)
    );

    alu_top #(
        .ADDR_W (ADDR_W)
    ) u_alu_top (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .alu_en       (alu_en),
        .alu_ready    (alu_ready),
        .alu_instbus  (alu_instbus),
        .alu_rs1_addr (alu_rs1_addr),
        .alu_rs2_addr (alu_rs2_addr),
        .alu_rs1_val  (alu_rs1_val),
        .alu_rs2_val  (alu_rs2_val),
        .alu_rd_wr    (alu_rd_wr),
        .alu_rd_addr  (alu_rd_addr),
        .alu_rd_val   (alu_rd_val),
        .alu_rd_strb  (alu_rd_strb),
        .mem_en       (mem_en),
        .mem_wr       (mem_wr),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_strb     (mem_strb),
        .mem_rdata    (mem_rdata),
        .mem_ready    (mem_ready)
    );

    //////////////////////////////////////////////////////////////////////
    // Instruction encoders
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, 5'd2, 5'd1, f3, rd, rv32i_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {imm, 5'd1, f3, rd, rv32i_pkg::OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_ld(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {imm, 5'd1, f3, rd, rv32i_pkg::OPC_LOAD};
    endfunction

    // Offset split into imm[11:5] and imm[4:0]
    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], rv32i_pkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, rv32i_pkg::OPC_LUI};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_xlen(input string name, input string field,
                              input rv32i_pkg::xlen_t exp, input rv32i_pkg::xlen_t act);
        if (act !== exp) begin
            val_errs++;
            $display("ERROR %s %s: expected %h, actual %h", name, field, exp, act);
        end
    endtask

    task automatic check_strb(input string name, input string field,
                              input rv32i_pkg::strb_t exp, input rv32i_pkg::strb_t act);
        if (act !== exp) begin
            val_errs++;
            $display("ERROR %s %s: expected %b, actual %b", name, field, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp,
                              input logic [ADDR_W-1:0] act);
        if (act !== exp) begin
            val_errs++;
            $display("ERROR %s mem_addr: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_rd(input string name, input string field,
                            input rv32i_pkg::reg_addr_t exp,
                            input rv32i_pkg::reg_addr_t act);
        if (act !== exp) begin
            val_errs++;
            $display("ERROR %s %s: expected %0d, actual %0d", name, field, exp, act);
        end
    endtask

    task automatic check_level(input string name, input string sig, input logic exp,
                               input logic act);
        if (act !== exp) begin
            proto_errs++;
            $display("%s: %s should be %s but is %s", name, sig,
                     exp ? "high" : "low", act ? "high" : "low");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test table
    //////////////////////////////////////////////////////////////////////

    task automatic add_test(input string name, input int kind, input logic [31:0] instr,
                            input rv32i_pkg::xlen_t rs1, input rv32i_pkg::xlen_t rs2,
                            input rv32i_pkg::xlen_t rdata, input rv32i_pkg::xlen_t exp_val,
                            input rv32i_pkg::strb_t exp_strb,
                            input logic [ADDR_W-1:0] exp_addr);
        tests[n_tests] = '{name, kind, instr, rs1, rs2, rdata, exp_val, exp_strb, exp_addr};
        n_tests++;
    endtask

    task automatic fill_table;
        add_test("add_ovf", K_RD, enc_r(7'h00, 3'd0, 5'd3), 32'h7fffffff, 32'h1, 0,
                 32'h80000000, 4'hf, 16'h0);
        add_test("sub_neg", K_RD, enc_r(7'h20, 3'd0, 5'd4), 32'h5, 32'h7, 0,
                 32'hfffffffe, 4'hf, 16'h0);
        add_test("sll_mask", K_RD, enc_r(7'h00, 3'd1, 5'd5), 32'h1, 32'h24, 0,
                 32'h10, 4'hf, 16'h0);
        add_test("slt_neg", K_RD, enc_r(7'h00, 3'd2, 5'd6), 32'h80000000, 32'h1, 0,
                 32'h1, 4'hf, 16'h0);
        add_test("sltu_big", K_RD, enc_r(7'h00, 3'd3, 5'd7), 32'h80000000, 32'h1, 0,
                 32'h0, 4'hf, 16'h0);
        add_test("slt_false", K_RD, enc_r(7'h00, 3'd2, 5'd8), 32'h1, 32'hffffffff, 0,
                 32'h0, 4'hf, 16'h0);
        add_test("sltu_true", K_RD, enc_r(7'h00, 3'd3, 5'd9), 32'h1, 32'hffffffff, 0,
                 32'h1, 4'hf, 16'h0);
        add_test("xor", K_RD, enc_r(7'h00, 3'd4, 5'd10), 32'hff00ff00, 32'h0ff00ff0, 0,
                 32'hf0f0f0f0, 4'hf, 16'h0);
        add_test("srl", K_RD, enc_r(7'h00, 3'd5, 5'd11), 32'h80000000, 32'h3f, 0,
                 32'h1, 4'hf, 16'h0);
        add_test("sra", K_RD, enc_r(7'h20, 3'd5, 5'd12), 32'h80000000, 32'h4, 0,
                 32'hf8000000, 4'hf, 16'h0);
        add_test("or", K_RD, enc_r(7'h00, 3'd6, 5'd13), 32'h12340000, 32'h00005678, 0,
                 32'h12345678, 4'hf, 16'h0);
        add_test("and", K_RD, enc_r(7'h00, 3'd7, 5'd14), 32'hf0f0f0f0, 32'hff00ff00, 0,
                 32'hf000f000, 4'hf, 16'h0);
        // rs2 holds junk for immediate forms
        add_test("addi_neg", K_RD, enc_i(12'hffc, 3'd0, 5'd15), 32'ha, 32'hdeadbeef, 0,
                 32'h6, 4'hf, 16'h0);
        add_test("slti_neg", K_RD, enc_i(12'hffd, 3'd2, 5'd16), 32'hfffffffb, 32'hdeadbeef,
                 0, 32'h1, 4'hf, 16'h0);
        add_test("sltiu_max", K_RD, enc_i(12'hfff, 3'd3, 5'd17), 32'h5, 32'hdeadbeef, 0,
                 32'h1, 4'hf, 16'h0);
        add_test("xori_not", K_RD, enc_i(12'hfff, 3'd4, 5'd18), 32'h0000ffff, 32'hdeadbeef,
                 0, 32'hffff0000, 4'hf, 16'h0);
        add_test("ori", K_RD, enc_i(12'h0f0, 3'd6, 5'd19), 32'h10000000, 32'hdeadbeef, 0,
                 32'h100000f0, 4'hf, 16'h0);
        add_test("andi", K_RD, enc_i(12'h0ff, 3'd7, 5'd20), 32'h12345678, 32'hdeadbeef, 0,
                 32'h78, 4'hf, 16'h0);
        add_test("slli", K_RD, enc_i(12'h008, 3'd1, 5'd21), 32'h00ab00cd, 32'hdeadbeef, 0,
                 32'hab00cd00, 4'hf, 16'h0);
        add_test("srli", K_RD, enc_i(12'h010, 3'd5, 5'd22), 32'hdead0000, 32'hdeadbeef, 0,
                 32'h0000dead, 4'hf, 16'h0);
        add_test("srai", K_RD, enc_i(12'h408, 3'd5, 5'd23), 32'h80000000, 32'hdeadbeef, 0,
                 32'hff800000, 4'hf, 16'h0);
        add_test("lui", K_RD, enc_u(20'habcde, 5'd24), 32'h0, 32'h0, 0,
                 32'habcde000, 4'hf, 16'h0);
        add_test("lb", K_LOAD, enc_ld(12'hffc, 3'd0, 5'd25), 32'h00001000, 32'h0,
                 32'h12345680, 32'hffffff80, 4'h1, 16'h0ffc);
        add_test("lbu", K_LOAD, enc_ld(12'h010, 3'd4, 5'd26), 32'h00002000, 32'h0,
                 32'h123456f0, 32'h000000f0, 4'h1, 16'h2010);
        add_test("lh", K_LOAD, enc_ld(12'h7fe, 3'd1, 5'd27), 32'h00003000, 32'h0,
                 32'habcd8001, 32'hffff8001, 4'h3, 16'h37fe);
        add_test("lhu", K_LOAD, enc_ld(12'h002, 3'd5, 5'd28), 32'h00004000, 32'h0,
                 32'h1234fedc, 32'h0000fedc, 4'h3, 16'h4002);
        add_test("lw", K_LOAD, enc_ld(12'h004, 3'd2, 5'd29), 32'h00015000, 32'h0,
                 32'hcafef00d, 32'hcafef00d, 4'hf, 16'h5004);
        add_test("sb", K_STORE, enc_s(12'hff8, 3'd0), 32'h00006000, 32'h11223344, 0,
                 32'h11223344, 4'h1, 16'h5ff8);
        add_test("sh", K_STORE, enc_s(12'h024, 3'd1), 32'h00007000, 32'ha5a5b6b6, 0,
                 32'ha5a5b6b6, 4'h3, 16'h7024);
        add_test("sw", K_STORE, enc_s(12'h7e1, 3'd2), 32'h00008000, 32'hdeadbeef, 0,
                 32'hdeadbeef, 4'hf, 16'h87e1);
        add_test("unknown_opc", K_NONE, {12'h123, 5'd1, 3'd0, 5'd31, 7'h7f}, 32'h1, 32'h2,
                 0, 32'h0, 4'h0, 16'h0);
        add_test("add_after", K_RD, enc_r(7'h00, 3'd0, 5'd1), 32'h1, 32'h2, 0,
                 32'h3, 4'hf, 16'h0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // One table entry, from issue to result
    //////////////////////////////////////////////////////////////////////

    task automatic check_request(input test_t t);
        check_level(t.name, "mem_en", 1'b1, mem_en);
        check_level(t.name, "alu_ready", 1'b0, alu_ready);
        check_level(t.name, "mem_wr", t.kind == K_STORE, mem_wr);
        check_addr(t.name, t.exp_addr, mem_addr);
        check_strb(t.name, "mem_strb", t.exp_strb, mem_strb);
        if (t.kind == K_STORE) begin
            check_xlen(t.name, "mem_wdata", t.exp_val, mem_wdata);
        end
    endtask

    task automatic run_test(input test_t t);
        int lat;

        alu_en      = 1'b1;
        alu_instbus = t.instr;
        alu_rs1_val = t.rs1;
        alu_rs2_val = t.rs2;
        while (!alu_ready) @(negedge aclk);
        // Accepted on the next rising edge
        @(negedge aclk);
        alu_en = 1'b0;
        // Instruction word is still on the bus here
        check_rd(t.name, "alu_rs1_addr", t.instr[19:15], alu_rs1_addr);
        check_rd(t.name, "alu_rs2_addr", t.instr[24:20], alu_rs2_addr);
        case (t.kind)
            K_RD: begin
                wr_expected++;
                check_level(t.name, "alu_rd_wr", 1'b1, alu_rd_wr);
                check_rd(t.name, "alu_rd_addr", t.instr[11:7], alu_rd_addr);
                check_xlen(t.name, "alu_rd_val", t.exp_val, alu_rd_val);
                check_strb(t.name, "alu_rd_strb", t.exp_strb, alu_rd_strb);
            end
            K_LOAD, K_STORE: begin
                check_request(t);
                lat = $unsigned($random(seed)) % 4;
                repeat (lat) begin
                    @(negedge aclk);
                    check_request(t);
                end
                mem_ready = 1'b1;
                mem_rdata = t.rdata;
                @(negedge aclk);
                mem_ready = 1'b0;
                mem_rdata = '0;
                check_level(t.name, "alu_ready", 1'b1, alu_ready);
                check_level(t.name, "mem_en", 1'b0, mem_en);
                check_level(t.name, "alu_rd_wr", t.kind == K_LOAD, alu_rd_wr);
                if (t.kind == K_LOAD) begin
                    wr_expected++;
                    check_rd(t.name, "alu_rd_addr", t.instr[11:7], alu_rd_addr);
                    check_xlen(t.name, "alu_rd_val", t.exp_val, alu_rd_val);
                    check_strb(t.name, "alu_rd_strb", t.exp_strb, alu_rd_strb);
                end
            end
            default: begin
                check_level(t.name, "alu_rd_wr", 1'b0, alu_rd_wr);
                check_level(t.name, "mem_en", 1'b0, mem_en);
                check_level(t.name, "alu_ready", 1'b1, alu_ready);
            end
        endcase
    endtask

    // Counts every write pulse, to catch extra or lost ones
    always @(negedge aclk) begin
        if (aresetn && alu_rd_wr) begin
            wr_seen++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the DUT stopped answering before all tests were applied");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        alu_en      = 1'b0;
        alu_instbus = '0;
        alu_rs1_val = '0;
        alu_rs2_val = '0;
        mem_rdata   = '0;
        mem_ready   = 1'b0;
        fill_table();

        @(negedge aclk);
        check_level("reset", "alu_ready", 1'b0, alu_ready);
        check_level("reset", "mem_en", 1'b0, mem_en);
        check_level("reset", "alu_rd_wr", 1'b0, alu_rd_wr);
        @(posedge aresetn);
        @(negedge aclk);
        check_level("reset release", "alu_ready", 1'b1, alu_ready);

        for (int i = 0; i < n_tests; i++) begin
            run_test(tests[i]);
        end
        repeat (2) @(negedge aclk);
        if (wr_seen != wr_expected) begin
            proto_errs++;
            $display("Register write pulses: %0d seen where %0d were expected",
                     wr_seen, wr_expected);
        end

        $display("Errors: %0d value, %0d protocol, over %0d tests",
                 val_errs, proto_errs, n_tests);
        if (val_errs == 0 && proto_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tb/tb_clk_gen.sv */
// Free-running testbench clock with an active-low reset at start.
// Reset is released on a falling edge, after RESET_CYCLES full periods.

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic aclk,
    output logic aresetn
);

    initial begin
        aclk = 1'b0;
        forever #(PERIOD_NS / 2) aclk = ~aclk;
    end

    initial begin
        aresetn = 1'b0;
        repeat (RESET_CYCLES) @(negedge aclk);
        aresetn = 1'b1;
    end

endmodule

/* hdl/alu_top.sv */
// RV32I execution and load/store unit, one instruction word per accept.
// Register file and data memory are outside; ADDR_W must not exceed XLEN.

`timescale 1ns/1ps

module alu_top #(
    parameter int ADDR_W = 16
) (
    input  logic                  aclk,
    input  logic                  aresetn,
    // Instruction
    input  logic                  alu_en,
    output logic                  alu_ready,
    input  rv32i_pkg::instr_t     alu_instbus,
    // Register read
    output rv32i_pkg::reg_addr_t  alu_rs1_addr,
    output rv32i_pkg::reg_addr_t  alu_rs2_addr,
    input  rv32i_pkg::xlen_t      alu_rs1_val,
    input  rv32i_pkg::xlen_t      alu_rs2_val,
    // Register write
    output logic                  alu_rd_wr,
    output rv32i_pkg::reg_addr_t  alu_rd_addr,
    output rv32i_pkg::xlen_t      alu_rd_val,
    output rv32i_pkg::strb_t      alu_rd_strb,
    // Data memory
    output logic                  mem_en,
    output logic                  mem_wr,
    output logic [ADDR_W-1:0]     mem_addr,
    output rv32i_pkg::xlen_t      mem_wdata,
    output rv32i_pkg::strb_t      mem_strb,
    input  rv32i_pkg::xlen_t      mem_rdata,
    input  logic                  mem_ready
);

    logic                 accept;
    logic                 alu_res_valid;
    rv32i_pkg::xlen_t     alu_res;
    rv32i_pkg::reg_addr_t alu_res_rd;
    logic                 load_valid;
    rv32i_pkg::xlen_t     load_data;
    rv32i_pkg::strb_t     load_strb;
    rv32i_pkg::reg_addr_t load_rd;

    // Source addresses sit at the same bits in every format that has them
    assign alu_rs1_addr = alu_instbus.r.rs1;
    assign alu_rs2_addr = alu_instbus.r.rs2;

    int_alu u_int_alu (
        .accept        (accept),
        .alu_instbus   (alu_instbus),
        .alu_rs1_val   (alu_rs1_val),
        .alu_rs2_val   (alu_rs2_val),
        .alu_res_valid (alu_res_valid),
        .alu_res       (alu_res),
        .alu_res_rd    (alu_res_rd)
    );

    lsu_ctrl #(
        .ADDR_W (ADDR_W)
    ) u_lsu_ctrl (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .alu_en      (alu_en),
        .alu_instbus (alu_instbus),
        .alu_rs1_val (alu_rs1_val),
        .alu_rs2_val (alu_rs2_val),
        .alu_ready   (alu_ready),
        .accept      (accept),
        .mem_en      (mem_en),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_strb    (mem_strb),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready),
        .load_valid  (load_valid),
        .load_data   (load_data),
        .load_strb   (load_strb),
        .load_rd     (load_rd)
    );

    rd_writeback u_rd_writeback (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .alu_res_valid (alu_res_valid),
        .alu_res       (alu_res),
        .alu_res_rd    (alu_res_rd),
        .load_valid    (load_valid),
        .load_data     (load_data),
        .load_strb     (load_strb),
        .load_rd       (load_rd),
        .alu_rd_wr     (alu_rd_wr),
        .alu_rd_addr   (alu_rd_addr),
        .alu_rd_val    (alu_rd_val),
        .alu_rd_strb   (alu_rd_strb)
    );

endmodule

/* hdl/rd_writeback.sv */
// Registered destination write port, one pulse per result.
// Sources are exclusive by construction; a load wins if both ever appear.

`timescale 1ns/1ps

module rd_writeback (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 alu_res_valid,
    input  rv32i_pkg::xlen_t     alu_res,
    input  rv32i_pkg::reg_addr_t alu_res_rd,
    input  logic                 load_valid,
    input  rv32i_pkg::xlen_t     load_data,
    input  rv32i_pkg::strb_t     load_strb,
    input  rv32i_pkg::reg_addr_t load_rd,
    output logic                 alu_rd_wr,
    output rv32i_pkg::reg_addr_t alu_rd_addr,
    output rv32i_pkg::xlen_t     alu_rd_val,
    output rv32i_pkg::strb_t     alu_rd_strb
);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            alu_rd_wr <= 1'b0;
        end else begin
            alu_rd_wr <= alu_res_valid || load_valid;
        end
    end

    // Payload only meaningful with alu_rd_wr
    always_ff @(posedge aclk) begin
        if (load_valid) begin
            alu_rd_addr <= load_rd;
            alu_rd_val  <= load_data;
            alu_rd_strb <= load_strb;
        end else if (alu_res_valid) begin
            alu_rd_addr <= alu_res_rd;
            alu_rd_val  <= alu_res;
            alu_rd_strb <= '1;
        end
    end

    // Issue stalls during a memory request, so the two never meet
    a_one_source: assert property (@(posedge aclk) disable iff (!aresetn)
        !(alu_res_valid && load_valid));

endmodule

/* lsu/lsu_ctrl.sv */
// Issue control and single outstanding load/store request.
// Little endian, byte and half accesses use the low lanes only, no alignment check.

`timescale 1ns/1ps

module lsu_ctrl #(
    parameter int ADDR_W = 16
) (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 alu_en,
    input  rv32i_pkg::instr_t    alu_instbus,
    input  rv32i_pkg::xlen_t     alu_rs1_val,
    input  rv32i_pkg::xlen_t     alu_rs2_val,
    output logic                 alu_ready,
    output logic                 accept,
    output logic                 mem_en,
    output logic                 mem_wr,
    output logic [ADDR_W-1:0]    mem_addr,
    output rv32i_pkg::xlen_t     mem_wdata,
    output rv32i_pkg::strb_t     mem_strb,
    input  rv32i_pkg::xlen_t     mem_rdata,
    input  logic                 mem_ready,
    output logic                 load_valid,
    output rv32i_pkg::xlen_t     load_data,
    output rv32i_pkg::strb_t     load_strb,
    output rv32i_pkg::reg_addr_t load_rd
);

    logic             is_load;
    logic             is_store;
    logic [11:0]      imm12;
    rv32i_pkg::xlen_t addr_sum;
    rv32i_pkg::strb_t width_strb;
    logic [2:0]       mem_f3;

    assign accept   = alu_en && alu_ready;
    assign is_load  = (alu_instbus.i.opcode == rv32i_pkg::OPC_LOAD);
    assign is_store = (alu_instbus.s.opcode == rv32i_pkg::OPC_STORE);

    // S form splits the offset, I form keeps it whole
    assign imm12    = is_store ? {alu_instbus.s.imm_hi, alu_instbus.s.imm_lo}
                               : alu_instbus.i.imm;
    assign addr_sum = alu_rs1_val + {{(rv32i_pkg::XLEN-12){imm12[11]}}, imm12};

    // Width from funct3[1:0], unsigned loads map the same way
    always_comb begin
        case (alu_instbus.i.funct3[1:0])
            2'b00:   width_strb = 4'b0001;
            2'b01:   width_strb = 4'b0011;
            default: width_strb = 4'b1111;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Busy control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            alu_ready <= 1'b0;
            mem_en    <= 1'b0;
            mem_wr    <= 1'b0;
        end else if (mem_en) begin
            if (mem_ready) begin
                mem_en    <= 1'b0;
                alu_ready <= 1'b1;
            end
        end else if (accept && (is_load || is_store)) begin
            mem_en    <= 1'b1;
            mem_wr    <= is_store;
            alu_ready <= 1'b0;
        end else begin
            alu_ready <= 1'b1;
        end
    end

    // Request held until mem_ready
    always_ff @(posedge aclk) begin
        if (accept && (is_load || is_store)) begin
            mem_addr  <= addr_sum[ADDR_W-1:0];
            mem_wdata <= alu_rs2_val;
            mem_strb  <= width_strb;
            mem_f3    <= alu_instbus.i.funct3;
            load_rd   <= alu_instbus.i.rd;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Load return
    //////////////////////////////////////////////////////////////////////

    assign load_valid = mem_en && mem_ready && !mem_wr;
    assign load_strb  = mem_strb;

    always_comb begin
        case (mem_f3)
            rv32i_pkg::F3_B:  load_data = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
            rv32i_pkg::F3_BU: load_data = {24'b0, mem_rdata[7:0]};
            rv32i_pkg::F3_H:  load_data = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
            rv32i_pkg::F3_HU: load_data = {16'b0, mem_rdata[15:0]};
            default:          load_data = mem_rdata;
        endcase
    end

    a_addr_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        mem_en && !mem_ready |=> $stable(mem_addr));

    // No issue while a request is outstanding
    a_no_issue_busy: assert property (@(posedge aclk) disable iff (!aresetn)
        !(mem_en && alu_ready));

endmodule

/* exec/int_alu.sv */
// Combinational integer datapath for OP, OP-IMM and LUI.
// Other opcodes leave alu_res_valid low; the result is then don't care.

`timescale 1ns/1ps

module int_alu (
    input  logic                 accept,
    input  rv32i_pkg::instr_t    alu_instbus,
    input  rv32i_pkg::xlen_t     alu_rs1_val,
    input  rv32i_pkg::xlen_t     alu_rs2_val,
    output logic                 alu_res_valid,
    output rv32i_pkg::xlen_t     alu_res,
    output rv32i_pkg::reg_addr_t alu_res_rd
);

    logic [6:0]                    opcode;
    logic [2:0]                    funct3;
    logic                          bit30;
    logic                          is_imm;
    rv32i_pkg::xlen_t              imm_i;
    rv32i_pkg::xlen_t              op_b;
    logic [4:0]                    shamt;
    logic signed [rv32i_pkg::XLEN-1:0] sra_res;
    rv32i_pkg::xlen_t              op_res;

    assign opcode = alu_instbus.r.opcode;
    assign funct3 = alu_instbus.r.funct3;
    assign bit30  = alu_instbus.r.funct7[5];
    assign is_imm = (opcode == rv32i_pkg::OPC_OP_IMM);

    assign imm_i = {{(rv32i_pkg::XLEN-12){alu_instbus.i.imm[11]}}, alu_instbus.i.imm};
    assign op_b  = is_imm ? imm_i : alu_rs2_val;

    // shamt field and rs2[4:0] share the low operand bits
    assign shamt = op_b[4:0];

    // Kept apart so the signed shift is not turned unsigned by a mux
    assign sra_res = $signed(alu_rs1_val) >>> shamt;

    always_comb begin
        op_res = '0;
        case (funct3)
            rv32i_pkg::F3_ADD: begin
                // addi has no sub form, bit 30 is immediate there
                if (!is_imm && bit30) begin
                    op_res = alu_rs1_val - op_b;
                end else begin
                    op_res = alu_rs1_val + op_b;
                end
            end
            rv32i_pkg::F3_SLL:  op_res = alu_rs1_val << shamt;
            rv32i_pkg::F3_SLT:  op_res = rv32i_pkg::xlen_t'($signed(alu_rs1_val) < $signed(op_b));
            rv32i_pkg::F3_SLTU: op_res = rv32i_pkg::xlen_t'(alu_rs1_val < op_b);
            rv32i_pkg::F3_XOR:  op_res = alu_rs1_val ^ op_b;
            rv32i_pkg::F3_SR: begin
                if (bit30) begin
                    op_res = sra_res;
                end else begin
                    op_res = alu_rs1_val >> shamt;
                end
            end
            rv32i_pkg::F3_OR:   op_res = alu_rs1_val | op_b;
            rv32i_pkg::F3_AND:  op_res = alu_rs1_val & op_b;
            default:            op_res = '0;
        endcase
    end

    assign alu_res = (opcode == rv32i_pkg::OPC_LUI) ? {alu_instbus.u.imm, 12'b0} : op_res;

    assign alu_res_rd    = alu_instbus.r.rd;
    assign alu_res_valid = accept && (opcode == rv32i_pkg::OPC_OP ||
                                      opcode == rv32i_pkg::OPC_OP_IMM ||
                                      opcode == rv32i_pkg::OPC_LUI);

endmodule

/* common/rv32i_pkg.sv */
// Shared widths, RV32I opcode and funct3 encodings, and instruction formats.
// Only the subset run by the execution and load/store unit is listed.

package rv32i_pkg;

    localparam int XLEN       = 32;
    localparam int STRB_W     = XLEN / 8;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [STRB_W-1:0]     strb_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    //////////////////////////////////////////////////////////////////////
    // Major opcodes
    //////////////////////////////////////////////////////////////////////

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // Arithmetic funct3, shared by register and immediate forms
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Access width funct3, loads and stores
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    //////////////////////////////////////////////////////////////////////
    // Instruction formats, MSB first
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // Immediate split around the rs fields
    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
    } instr_t;

endpackage
